//--- filelist.f
logic/id_pkg.sv
logic/expand_if.sv
logic/rvc_expander.sv
logic/instr_decoder.sv
logic/issue_register.sv
logic/id_stage_top.sv
testbench/id_stage_props.sv
testbench/tb_id_stage.sv

//--- logic/expand_if.sv
// ----------------------------------------------------------------------
// Expanded instruction link from the compressed expander to the
// RV32I decoder
// ----------------------------------------------------------------------
interface expand_if
  import id_pkg::*;
();

  // Always a 32-bit word, even for an illegal compressed encoding
  logic [ILEN-1:0] instr;
  logic [XLEN-1:0] pc;
  logic            is_compressed;
  logic            illegal;

  modport exp (
    output instr,
    output pc,
    output is_compressed,
    output illegal
  );

  modport dec (
    input instr,
    input pc,
    input is_compressed,
    input illegal
  );

endinterface

//--- logic/id_pkg.sv
// ----------------------------------------------------------------------
// Shared definitions for the decode stage
// Widths, RV32I major opcodes, functional unit and operation types,
// and the entry handed from decode to issue
// ----------------------------------------------------------------------
package id_pkg;

  // Widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned CILEN      = 16;
  localparam int unsigned REG_ADDR_W = 5;

  // ----------------------------------------------------------------------
  // Major opcodes (instr[6:0])
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // Functional unit selected at issue
  typedef enum logic [1:0] {
    FU_ALU       = 2'd0,
    FU_LOAD      = 2'd1,
    FU_STORE     = 2'd2,
    FU_CTRL_FLOW = 2'd3
  } fu_t;

  // ALU ops are {subtract/arith bit, funct3}
  // Branch, load and store ops are {1'b0, funct3}
  typedef logic [3:0] op_t;

  localparam op_t OP_ADD = 4'b0000;

  // ----------------------------------------------------------------------
  // Decode to issue entry
  // ----------------------------------------------------------------------
  typedef struct packed {
    fu_t                   fu;
    op_t                   op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic                  illegal;
    logic                  is_compressed;
    logic                  is_ctrl_flow;
  } issue_entry_t;

endpackage

//--- logic/id_stage_top.sv
// ----------------------------------------------------------------------
// Decode stage top level
// Compressed expander, RV32I decoder and decode/issue register
// ----------------------------------------------------------------------
module id_stage_top
  import id_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  // Fetch side
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,
  input  logic [ILEN-1:0]       fetch_instr_i,
  input  logic [XLEN-1:0]       fetch_pc_i,
  // Issue side
  output logic                  issue_valid_o,
  input  logic                  issue_ack_i,
  output fu_t                   issue_fu_o,
  output op_t                   issue_op_o,
  output logic [REG_ADDR_W-1:0] issue_rs1_o,
  output logic [REG_ADDR_W-1:0] issue_rs2_o,
  output logic [REG_ADDR_W-1:0] issue_rd_o,
  output logic [XLEN-1:0]       issue_imm_o,
  output logic [XLEN-1:0]       issue_pc_o,
  output logic                  issue_illegal_o,
  output logic                  issue_is_compressed_o,
  output logic                  issue_ctrl_flow_o,
  output logic [ILEN-1:0]       issue_orig_instr_o
);

  issue_entry_t dec_entry;
  issue_entry_t issue_entry;

  expand_if exp_if ();

  rvc_expander rvc_expander_inst (
    .instr_i (fetch_instr_i),
    .pc_i    (fetch_pc_i),
    .exp_o   (exp_if.exp)
  );

  instr_decoder instr_decoder_inst (
    .in_i    (exp_if.dec),
    .entry_o (dec_entry)
  );

  issue_register issue_register_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .entry_i       (dec_entry),
    .orig_instr_i  (fetch_instr_i),
    .issue_ack_i   (issue_ack_i),
    .issue_valid_o (issue_valid_o),
    .entry_o       (issue_entry),
    .orig_instr_o  (issue_orig_instr_o)
  );

  // Entry fields out to plain ports
  assign issue_fu_o            = issue_entry.fu;
  assign issue_op_o            = issue_entry.op;
  assign issue_rs1_o           = issue_entry.rs1;
  assign issue_rs2_o           = issue_entry.rs2;
  assign issue_rd_o            = issue_entry.rd;
  assign issue_imm_o           = issue_entry.imm;
  assign issue_pc_o            = issue_entry.pc;
  assign issue_illegal_o       = issue_entry.illegal;
  assign issue_is_compressed_o = issue_entry.is_compressed;
  assign issue_ctrl_flow_o     = issue_entry.is_ctrl_flow;

endmodule

//--- logic/instr_decoder.sv
// ----------------------------------------------------------------------
// RV32I decoder
// Functional unit, operation, registers and immediate of one
// expanded instruction, plus illegal and control-flow flags
// ----------------------------------------------------------------------
module instr_decoder
  import id_pkg::*;
(
  expand_if.dec        in_i,
  output issue_entry_t entry_o
);

  logic [ILEN-1:0] instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign instr  = in_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ----------------------------------------------------------------------
  // Immediate formats, sign-extended
  // ----------------------------------------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    entry_o               = '0;
    entry_o.fu            = FU_ALU;
    entry_o.op            = OP_ADD;
    entry_o.rs1           = instr[19:15];
    entry_o.rs2           = instr[24:20];
    entry_o.rd            = instr[11:7];
    entry_o.pc            = in_i.pc;
    entry_o.is_compressed = in_i.is_compressed;
    entry_o.illegal       = in_i.illegal;

    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        entry_o.rs1 = '0;
        entry_o.rs2 = '0;
        entry_o.imm = imm_u;
      end
      OPC_JAL: begin
        entry_o.fu           = FU_CTRL_FLOW;
        entry_o.rs1          = '0;
        entry_o.rs2          = '0;
        entry_o.imm          = imm_j;
        entry_o.is_ctrl_flow = 1'b1;
      end
      OPC_JALR: begin
        entry_o.fu           = FU_CTRL_FLOW;
        entry_o.op           = {1'b0, funct3};
        entry_o.rs2          = '0;
        entry_o.imm          = imm_i;
        entry_o.is_ctrl_flow = 1'b1;
      end
      OPC_BRANCH: begin
        entry_o.fu           = FU_CTRL_FLOW;
        entry_o.op           = {1'b0, funct3};
        entry_o.rd           = '0;
        entry_o.imm          = imm_b;
        entry_o.is_ctrl_flow = 1'b1;
        // funct3 010 and 011 are not branches
        entry_o.illegal      = entry_o.illegal | (funct3[2:1] == 2'b01);
      end
      OPC_LOAD: begin
        entry_o.fu      = FU_LOAD;
        entry_o.op      = {1'b0, funct3};
        entry_o.rs2     = '0;
        entry_o.imm     = imm_i;
        entry_o.illegal = entry_o.illegal | (funct3 == 3'b011) | (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        entry_o.fu      = FU_STORE;
        entry_o.op      = {1'b0, funct3};
        entry_o.rd      = '0;
        entry_o.imm     = imm_s;
        entry_o.illegal = entry_o.illegal | (funct3 > 3'b010);
      end
      OPC_OP_IMM: begin
        // Only SRAI carries the arithmetic bit, elsewhere it is immediate
        entry_o.op  = {(funct3 == 3'b101) & instr[30], funct3};
        entry_o.rs2 = '0;
        entry_o.imm = imm_i;
      end
      OPC_OP: begin
        entry_o.op = {instr[30], funct3};
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          entry_o.illegal = 1'b1;
        end
      end
      default: entry_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- logic/issue_register.sv
// ----------------------------------------------------------------------
// One-entry decode/issue register
// Fetch valid/ready in, issue valid/ack out, flush drops the entry
// ----------------------------------------------------------------------
module issue_register
  import id_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic            fetch_valid_i,
  output logic            fetch_ready_o,
  input  issue_entry_t    entry_i,
  input  logic [ILEN-1:0] orig_instr_i,
  input  logic            issue_ack_i,
  output logic            issue_valid_o,
  output issue_entry_t    entry_o,
  output logic [ILEN-1:0] orig_instr_o
);

  logic            valid_q;
  logic            transfer;
  issue_entry_t    entry_q;
  logic [ILEN-1:0] instr_q;

  // Room when empty or when the held entry leaves this cycle
  assign fetch_ready_o = ~valid_q | issue_ack_i;
  assign transfer      = fetch_valid_i & fetch_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (transfer) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on a transfer, so it holds while waiting for ack
  always_ff @(posedge clk_i) begin
    if (transfer) begin
      entry_q <= entry_i;
      instr_q <= orig_instr_i;
    end
  end

  assign issue_valid_o = valid_q;
  assign entry_o       = entry_q;
  assign orig_instr_o  = instr_q;

endmodule

//--- logic/rvc_expander.sv
// ----------------------------------------------------------------------
// Compressed instruction expander
// Maps C.ADDI, C.LI, C.MV, C.ADD, C.LW, C.SW, C.J and C.BEQZ to RV32I,
// flags every other compressed encoding as illegal
// ----------------------------------------------------------------------
module rvc_expander
  import id_pkg::*;
(
  input  logic [ILEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  expand_if.exp           exp_o
);

  logic [CILEN-1:0] c;
  logic [2:0]       funct3;
  logic [ILEN-1:0]  instr_exp;
  logic             illegal;

  assign c      = instr_i[CILEN-1:0];
  assign funct3 = c[15:13];

  always_comb begin
    instr_exp = instr_i;
    illegal   = 1'b0;

    case (c[1:0])
      // ------------------------------------------------------------------
      // Quadrant 0
      // ------------------------------------------------------------------
      2'b00: begin
        case (funct3)
          // c.lw -> lw rd', uimm(rs1')
          3'b010: instr_exp = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7],
                               3'b010, 2'b01, c[4:2], OPC_LOAD};
          // c.sw -> sw rs2', uimm(rs1')
          3'b110: instr_exp = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                               3'b010, c[11:10], c[6], 2'b00, OPC_STORE};
          default: illegal = 1'b1;
        endcase
      end

      // ------------------------------------------------------------------
      // Quadrant 1
      // ------------------------------------------------------------------
      2'b01: begin
        case (funct3)
          // c.addi -> addi rd, rd, imm
          3'b000: instr_exp = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7],
                               OPC_OP_IMM};
          // c.li -> addi rd, x0, imm
          3'b010: instr_exp = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7],
                               OPC_OP_IMM};
          // c.j -> jal x0, offset
          3'b101: instr_exp = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                               c[12], {8{c[12]}}, 5'b0, OPC_JAL};
          // c.beqz -> beq rs1', x0, offset
          3'b110: instr_exp = {c[12], {3{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7],
                               3'b000, c[11:10], c[4:3], c[12], OPC_BRANCH};
          default: illegal = 1'b1;
        endcase
      end

      // ------------------------------------------------------------------
      // Quadrant 2
      // ------------------------------------------------------------------
      2'b10: begin
        // rs2 == 0 would be c.jr, c.jalr or c.ebreak
        if (funct3 == 3'b100 && c[6:2] != 5'b0) begin
          if (c[12]) begin
            // c.add -> add rd, rd, rs2
            instr_exp = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP};
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_exp = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], OPC_OP};
          end
        end else begin
          illegal = 1'b1;
        end
      end

      // Full 32-bit word
      default: instr_exp = instr_i;
    endcase
  end

  assign exp_o.instr         = instr_exp;
  assign exp_o.pc            = pc_i;
  assign exp_o.is_compressed = (c[1:0] != 2'b11);
  assign exp_o.illegal       = illegal;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage -o sim_id_stage \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_id_stage +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && { echo "Simulation passed"; exit 0; } \
  || { echo "No verdict found in sim.log"; exit 1; }

//--- testbench/id_stage_props.sv
// ----------------------------------------------------------------------
// Concurrent checks on the decode stage handshakes and flush
// Bound to the decode stage top level
// ----------------------------------------------------------------------
module id_stage_props
  import id_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  flush_i,
  input logic                  fetch_valid_i,
  input logic                  fetch_ready_o,
  input logic [ILEN-1:0]       fetch_instr_i,
  input logic [XLEN-1:0]       fetch_pc_i,
  input logic                  issue_valid_o,
  input logic                  issue_ack_i,
  input fu_t                   issue_fu_o,
  input op_t                   issue_op_o,
  input logic [REG_ADDR_W-1:0] issue_rs1_o,
  input logic [REG_ADDR_W-1:0] issue_rs2_o,
  input logic [REG_ADDR_W-1:0] issue_rd_o,
  input logic [XLEN-1:0]       issue_imm_o,
  input logic [XLEN-1:0]       issue_pc_o,
  input logic                  issue_illegal_o,
  input logic                  issue_is_compressed_o,
  input logic                  issue_ctrl_flow_o,
  input logic [ILEN-1:0]       issue_orig_instr_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [$bits(issue_entry_t)+ILEN-1:0] issue_bits;

  // Failure counts per property
  int unsigned reset_fails = 0;
  int unsigned ready_fails = 0;
  int unsigned hold_fails  = 0;
  int unsigned keep_fails  = 0;
  int unsigned xfer_fails  = 0;
  int unsigned flush_fails = 0;
  int unsigned fail_total;

  assign fail_total = reset_fails + ready_fails + hold_fails + keep_fails + xfer_fails +
                      flush_fails;

  // Every issue output except the valid flag
  assign issue_bits = {issue_fu_o, issue_op_o, issue_rs1_o, issue_rs2_o, issue_rd_o,
                       issue_imm_o, issue_pc_o, issue_illegal_o, issue_is_compressed_o,
                       issue_ctrl_flow_o, issue_orig_instr_o};

  // ----------------------------------------------------------------------
  // Reset state
  // ----------------------------------------------------------------------
  a_reset: assert property (@(posedge clk_i) !rst_ni |=> !issue_valid_o && fetch_ready_o)
    else begin
      $error("issue_valid_o high or fetch_ready_o low in or right after reset");
      reset_fails = reset_fails + 1;
    end

  // ----------------------------------------------------------------------
  // Back-pressure
  // ----------------------------------------------------------------------
  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i |-> !fetch_ready_o)
    else begin
      $error("fetch_ready_o high while an entry waits for issue_ack_i");
      ready_fails = ready_fails + 1;
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i |=> $stable(issue_bits))
    else begin
      $error("Issue outputs changed while waiting for issue_ack_i");
      hold_fails = hold_fails + 1;
    end

  a_keep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i && !flush_i |=> issue_valid_o)
    else begin
      $error("issue_valid_o dropped without issue_ack_i or flush_i");
      keep_fails = keep_fails + 1;
    end

  // ----------------------------------------------------------------------
  // Transfer and flush
  // ----------------------------------------------------------------------
  a_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && fetch_ready_o && !flush_i |=>
      issue_valid_o && issue_orig_instr_o == $past(fetch_instr_i) &&
      issue_pc_o == $past(fetch_pc_i))
    else begin
      $error("Fetch transfer not presented on the issue outputs one cycle later");
      xfer_fails = xfer_fails + 1;
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !issue_valid_o)
    else begin
      $error("issue_valid_o high in the cycle after flush_i");
      flush_fails = flush_fails + 1;
    end

endmodule

bind id_stage_top id_stage_props handshake_props_inst (.*);

//--- testbench/tb_id_stage.sv
// ----------------------------------------------------------------------
// Testbench for the decode stage
// Reset, back-pressure, flush, compressed equivalence and decode rules
// under random ack delays, with a watchdog and a final verdict
// ----------------------------------------------------------------------
module tb_id_stage
  import id_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD       = 20;
  localparam int RESET_CYCLES     = 16;
  localparam int WAIT_LIMIT       = 20;
  localparam int N_INSTR          = 32;
  localparam int CYCLES_PER_INSTR = 10;
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + N_INSTR * CYCLES_PER_INSTR + 100;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  fetch_valid_i;
  logic                  fetch_ready_o;
  logic [ILEN-1:0]       fetch_instr_i;
  logic [XLEN-1:0]       fetch_pc_i;
  logic                  issue_valid_o;
  logic                  issue_ack_i;
  fu_t                   issue_fu_o;
  op_t                   issue_op_o;
  logic [REG_ADDR_W-1:0] issue_rs1_o;
  logic [REG_ADDR_W-1:0] issue_rs2_o;
  logic [REG_ADDR_W-1:0] issue_rd_o;
  logic [XLEN-1:0]       issue_imm_o;
  logic [XLEN-1:0]       issue_pc_o;
  logic                  issue_illegal_o;
  logic                  issue_is_compressed_o;
  logic                  issue_ctrl_flow_o;
  logic [ILEN-1:0]       issue_orig_instr_o;

  integer          seed = 32'hba37_80fd;
  logic [XLEN-1:0] pc_next = 32'h0000_1000;
  int unsigned     checks = 0;
  int unsigned     errors = 0;
  int unsigned     tests_run = 0;
  int unsigned     checks_at_start;
  int unsigned     errors_at_start;

  id_stage_top id_stage_top_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .fetch_valid_i         (fetch_valid_i),
    .fetch_ready_o         (fetch_ready_o),
    .fetch_instr_i         (fetch_instr_i),
    .fetch_pc_i            (fetch_pc_i),
    .issue_valid_o         (issue_valid_o),
    .issue_ack_i           (issue_ack_i),
    .issue_fu_o            (issue_fu_o),
    .issue_op_o            (issue_op_o),
    .issue_rs1_o           (issue_rs1_o),
    .issue_rs2_o           (issue_rs2_o),
    .issue_rd_o            (issue_rd_o),
    .issue_imm_o           (issue_imm_o),
    .issue_pc_o            (issue_pc_o),
    .issue_illegal_o       (issue_illegal_o),
    .issue_is_compressed_o (issue_is_compressed_o),
    .issue_ctrl_flow_o     (issue_ctrl_flow_o),
    .issue_orig_instr_o    (issue_orig_instr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Own checks plus the bound handshake assertions
  function automatic int unsigned total_errors();
    return errors + id_stage_top_inst.handshake_props_inst.fail_total;
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic start_test();
    checks_at_start = checks;
    errors_at_start = total_errors();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %s: %0d checks, %0d errors", name, checks - checks_at_start,
             total_errors() - errors_at_start);
  endtask

  // Polls at falling edges, where the issue outputs are settled
  task automatic wait_issue_valid(input logic level);
    int n;
    n = 0;
    while (issue_valid_o !== level && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (issue_valid_o !== level) begin
      $display("Timeout waiting for issue_valid_o to become %0b", level);
      errors++;
    end
  endtask

  task automatic send_instr(input logic [31:0] instr, input logic [31:0] pc);
    fetch_valid_i = 1'b1;
    fetch_instr_i = instr;
    fetch_pc_i    = pc;
    @(negedge clk_i);
    wait_issue_valid(1'b1);
    fetch_valid_i = 1'b0;
  endtask

  task automatic ack_and_drain();
    issue_ack_i = 1'b1;
    @(negedge clk_i);
    issue_ack_i = 1'b0;
    wait_issue_valid(1'b0);
  endtask

  // Issue one word, stall the ack for a random time, then capture
  task automatic issue_and_capture(input logic [31:0] instr, output issue_entry_t e);
    int unsigned stall;
    stall = $unsigned($random(seed)) % 32'd4;
    send_instr(instr, pc_next);
    pc_next = pc_next + 32'd4;
    repeat (stall) @(negedge clk_i);
    e.fu            = issue_fu_o;
    e.op            = issue_op_o;
    e.rs1           = issue_rs1_o;
    e.rs2           = issue_rs2_o;
    e.rd            = issue_rd_o;
    e.imm           = issue_imm_o;
    e.pc            = issue_pc_o;
    e.illegal       = issue_illegal_o;
    e.is_compressed = issue_is_compressed_o;
    e.is_ctrl_flow  = issue_ctrl_flow_o;
    ack_and_drain();
  endtask

  task automatic check_pair(input logic [15:0] c_instr, input logic [31:0] full_instr,
                            input fu_t fu, input logic cf);
    issue_entry_t ce;
    issue_entry_t fe;
    issue_and_capture({16'h0000, c_instr}, ce);
    issue_and_capture(full_instr, fe);
    check_hex("issue_fu_o", 32'(ce.fu), 32'(fu));
    check_hex("issue_fu_o", 32'(fe.fu), 32'(fu));
    check_hex("issue_ctrl_flow_o", 32'(ce.is_ctrl_flow), 32'(cf));
    check_hex("issue_ctrl_flow_o", 32'(fe.is_ctrl_flow), 32'(cf));
    check_hex("issue_op_o", 32'(ce.op), 32'(fe.op));
    check_hex("issue_rs1_o", 32'(ce.rs1), 32'(fe.rs1));
    check_hex("issue_rs2_o", 32'(ce.rs2), 32'(fe.rs2));
    check_hex("issue_rd_o", 32'(ce.rd), 32'(fe.rd));
    check_hex("issue_imm_o", ce.imm, fe.imm);
    check_hex("issue_is_compressed_o", 32'(ce.is_compressed), 32'd1);
    check_hex("issue_is_compressed_o", 32'(fe.is_compressed), 32'd0);
    check_hex("issue_illegal_o", 32'(ce.illegal | fe.illegal), 32'd0);
  endtask

  task automatic check_decode(input logic [31:0] instr, input fu_t fu, input logic cf,
                              input logic ill);
    issue_entry_t e;
    issue_and_capture(instr, e);
    check_hex("issue_illegal_o", 32'(e.illegal), 32'(ill));
    if (!ill) begin
      check_hex("issue_fu_o", 32'(e.fu), 32'(fu));
      check_hex("issue_ctrl_flow_o", 32'(e.is_ctrl_flow), 32'(cf));
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    issue_ack_i   = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_test();
    check_hex("issue_valid_o", 32'(issue_valid_o), 32'd0);
    check_hex("fetch_ready_o", 32'(fetch_ready_o), 32'd1);
    finish_test("reset");

    // Second word waits at fetch while the first one is held
    start_test();
    send_instr(32'h0010_8093, 32'h0000_0100);
    fetch_valid_i = 1'b1;
    fetch_instr_i = 32'h4020_81b3;
    fetch_pc_i    = 32'h0000_0104;
    repeat (4) @(negedge clk_i);
    check_hex("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
    check_hex("issue_orig_instr_o", issue_orig_instr_o, 32'h0010_8093);
    issue_ack_i = 1'b1;
    @(negedge clk_i);
    check_hex("issue_valid_o", 32'(issue_valid_o), 32'd1);
    check_hex("issue_orig_instr_o", issue_orig_instr_o, 32'h4020_81b3);
    issue_ack_i   = 1'b0;
    fetch_valid_i = 1'b0;
    ack_and_drain();
    finish_test("backpressure");

    // Flush together with an ack and a fetch transfer at the same edge
    start_test();
    send_instr(32'h0032_2023, 32'h0000_0200);
    flush_i       = 1'b1;
    issue_ack_i   = 1'b1;
    fetch_valid_i = 1'b1;
    fetch_instr_i = 32'h0002_2183;
    fetch_pc_i    = 32'h0000_0204;
    @(negedge clk_i);
    check_hex("issue_valid_o", 32'(issue_valid_o), 32'd0);
    flush_i       = 1'b0;
    issue_ack_i   = 1'b0;
    fetch_valid_i = 1'b0;
    finish_test("flush");

    start_test();
    check_pair(16'h028d, 32'h0032_8293, FU_ALU, 1'b0);       // c.addi x5, 3
    check_pair(16'h557d, 32'hfff0_0513, FU_ALU, 1'b0);       // c.li x10, -1
    check_pair(16'h8426, 32'h0090_0433, FU_ALU, 1'b0);       // c.mv x8, x9
    check_pair(16'h9426, 32'h0094_0433, FU_ALU, 1'b0);       // c.add x8, x9
    check_pair(16'h4144, 32'h0045_2483, FU_LOAD, 1'b0);      // c.lw x9, 4(x10)
    check_pair(16'hc504, 32'h0095_2423, FU_STORE, 1'b0);     // c.sw x9, 8(x10)
    check_pair(16'ha021, 32'h0080_006f, FU_CTRL_FLOW, 1'b1); // c.j +8
    check_pair(16'hc011, 32'h0004_0263, FU_CTRL_FLOW, 1'b1); // c.beqz x8, +4
    finish_test("compressed");

    start_test();
    check_decode(32'h1234_50b7, FU_ALU, 1'b0, 1'b0);
    check_decode(32'h0000_1117, FU_ALU, 1'b0, 1'b0);
    check_decode(32'h0100_00ef, FU_CTRL_FLOW, 1'b1, 1'b0);
    check_decode(32'h0002_80e7, FU_CTRL_FLOW, 1'b1, 1'b0);
    check_decode(32'h0020_9463, FU_CTRL_FLOW, 1'b1, 1'b0);
    check_decode(32'h0002_2183, FU_LOAD, 1'b0, 1'b0);
    check_decode(32'h0032_2023, FU_STORE, 1'b0, 1'b0);
    check_decode(32'h0010_8093, FU_ALU, 1'b0, 1'b0);
    check_decode(32'h4020_81b3, FU_ALU, 1'b0, 1'b0);
    // Unknown opcode, then c.lwsp and c.addi4spn
    check_decode(32'h0000_000b, FU_ALU, 1'b0, 1'b1);
    check_decode(32'h0000_4082, FU_ALU, 1'b0, 1'b1);
    check_decode(32'h0000_0000, FU_ALU, 1'b0, 1'b1);
    finish_test("decode");

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, total_errors());
    if (total_errors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
